//--- iram_stimulus.txt
# test op(W write, R read, B both) address data expected_q expected_parity_error
# hex address and words, bit 48 is odd parity, unused fields are 0
1 W 0000 0000000000001 0000000000000 0
1 W 0fff 1123456789abc 0000000000000 0
1 W 1000 1ffffffffffff 0000000000000 0
1 W 1fff 1000000000000 0000000000000 0
1 W 2000 1a5a5a5a5a5a5 0000000000000 0
1 W 2fff 00f0f0f0f0f0e 0000000000000 0
1 W 3000 0deadbeef0001 0000000000000 0
1 W 3fff 1000000000003 0000000000000 0
1 R 0000 0000000000000 0000000000001 0
1 R 0fff 0000000000000 1123456789abc 0
1 R 1000 0000000000000 1ffffffffffff 0
1 R 1fff 0000000000000 1000000000000 0
1 R 2000 0000000000000 1a5a5a5a5a5a5 0
1 R 2fff 0000000000000 00f0f0f0f0f0e 0
1 R 3000 0000000000000 0deadbeef0001 0
1 R 3fff 0000000000000 1000000000003 0
2 R 3fff 0000000000000 1000000000003 0
2 R 0000 0000000000000 0000000000001 0
2 R 2000 0000000000000 1a5a5a5a5a5a5 0
2 R 1fff 0000000000000 1000000000000 0
2 R 3000 0000000000000 0deadbeef0001 0
2 R 0fff 0000000000000 1123456789abc 0
3 W 0123 0100000000000 0000000000000 0
3 B 0123 100000000ff00 0100000000000 0
3 R 0123 0000000000000 100000000ff00 0
3 W 2abc 1777777777777 0000000000000 0
3 B 2abc 0000000000007 1777777777777 0
3 R 2abc 0000000000000 0000000000007 0
4 W 0555 0000000000001 0000000000000 0
4 W 1555 1000000000003 0000000000000 0
4 W 2555 00f0f0f0f0f0e 0000000000000 0
4 W 3555 1a5a5a5a5a5a5 0000000000000 0
4 R 0555 0000000000000 0000000000001 0
4 R 1555 0000000000000 1000000000003 0
4 R 2555 0000000000000 00f0f0f0f0f0e 0
4 R 3555 0000000000000 1a5a5a5a5a5a5 0
5 W 0040 0deadbeef0001 0000000000000 0
5 W 1040 0000000000003 0000000000000 0
5 W 2040 1000000000001 0000000000000 0
5 W 3040 0ffffffffffff 0000000000000 0
5 W 0041 0000000000000 0000000000000 0
5 R 0040 0000000000000 0deadbeef0001 0
5 R 1040 0000000000000 0000000000003 1
5 R 2040 0000000000000 1000000000001 1
5 R 3040 0000000000000 0ffffffffffff 1
5 R 0041 0000000000000 0000000000000 1

//--- sources.f
iram_pkg.sv
iram_bank.sv
iram_bank_select.sv
iram_read_mux.sv
iram_top.sv
iram_properties.sv
tb_iram.sv

//--- Makefile
# Verilator build and run of the IRAM testbench

VERILATOR ?= verilator
TOP       ?= tb_iram
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_iram.sv
// testbench for the IRAM top level
// replays write and read records from the stimulus file, checks q and parity_error
module tb_iram;
   timeunit 1ns;
   timeprecision 100ps;

   import iram_pkg::*;

   localparam int    clk_period   = 8;
   localparam int    read_latency = 3;    // drive cycle to q_valid cycle
   localparam int    drain_limit  = 20;   // cycles allowed for reads in flight
   localparam string stim_file    = "iram_stimulus.txt";

   logic       clk_a;
   logic       arst_n;
   iram_addr_t address;
   iram_word_t data;
   logic       wren;
   logic       rden;
   iram_word_t q;
   logic       q_valid;
   logic       parity_error;

   // reads in flight in issue order
   iram_word_t exp_word_q [$];
   logic       exp_perr_q [$];
   int         issue_q    [$];       // cycle the rden was driven in

   int cycle_cnt  = 0;
   int errors     = 0;
   int tests_run  = 0;
   int tests_fail = 0;
   bit timed_out  = 1'b0;

   iram_top dut0 (
      .clk_a        (clk_a),
      .arst_n       (arst_n),
      .address      (address),
      .data         (data),
      .wren         (wren),
      .rden         (rden),
      .q            (q),
      .q_valid      (q_valid),
      .parity_error (parity_error)
   );

   initial
   begin
      clk_a = 1'b0;
      forever
      begin
         #(clk_period / 2) clk_a = ~clk_a;
      end
   end

   always @(posedge clk_a)
   begin
      cycle_cnt <= cycle_cnt + 1;
   end

   function automatic string test_name(input int id);
      case (id)
         1:       return "write and read back";
         2:       return "pipelined reads";
         3:       return "read-first";
         4:       return "bank isolation";
         5:       return "parity";
         6:       return "reset";
         default: return "unnamed";
      endcase
   endfunction

   // oldest read against the word now on q
   task automatic check_read();
      iram_word_t exp_word;
      logic       exp_perr;
      int         issued;
      exp_word = exp_word_q.pop_front();
      exp_perr = exp_perr_q.pop_front();
      issued   = issue_q.pop_front();
      if (q !== exp_word)
      begin
         $display("mismatch at %0t: q expected %h got %h", $time, exp_word, q);
         errors++;
      end
      if (parity_error !== exp_perr)
      begin
         $display("mismatch at %0t: parity_error expected %b got %b",
                  $time, exp_perr, parity_error);
         errors++;
      end
      // driven after edge k and sampled at k+1 so q_valid follows edge k+3
      if (cycle_cnt - issued != read_latency)
      begin
         $display("mismatch at %0t: q_valid latency expected %0d got %0d",
                  $time, read_latency, cycle_cnt - issued);
         errors++;
      end
   endtask

   // outputs are settled mid cycle
   always @(negedge clk_a)
   begin
      if (!arst_n)
      begin
         if (q_valid !== 1'b0 || parity_error !== 1'b0)
         begin
            $display("error at %0t: q_valid or parity_error high during reset", $time);
            errors++;
         end
      end
      else if (q_valid === 1'b1)
      begin
         if (exp_word_q.size() == 0)
         begin
            $display("error at %0t: q_valid high with no read pending", $time);
            errors++;
         end
         else
         begin
            check_read();
         end
      end
      else if (parity_error !== 1'b0)
      begin
         $display("mismatch at %0t: parity_error expected 0 got %b", $time, parity_error);
         errors++;
      end
   end

   task automatic apply_record(input logic [7:0] op, input iram_addr_t addr,
                               input iram_word_t wdata, input iram_word_t exp_word,
                               input logic exp_perr);
      @(posedge clk_a);
      #1;
      address = addr;
      data    = wdata;
      wren    = (op == "W") || (op == "B");
      rden    = (op == "R") || (op == "B");   // B is a read-first write
      if (rden)
      begin
         exp_word_q.push_back(exp_word);
         exp_perr_q.push_back(exp_perr);
         issue_q.push_back(cycle_cnt);
      end
   endtask

   // stop strobing and let every read come back
   task automatic wait_for_reads();
      int waited;
      @(posedge clk_a);
      #1;
      wren   = 1'b0;
      rden   = 1'b0;
      waited = 0;
      while (exp_word_q.size() != 0 && waited < drain_limit)
      begin
         @(posedge clk_a);
         waited++;
      end
      if (exp_word_q.size() != 0)
      begin
         $display("timeout at %0t: %0d reads got no q_valid within %0d cycles",
                  $time, exp_word_q.size(), drain_limit);
         errors++;
         timed_out = 1'b1;
         exp_word_q.delete();
         exp_perr_q.delete();
         issue_q.delete();
      end
   endtask

   task automatic close_test(input int id, input int base);
      tests_run++;
      if (errors == base)
      begin
         $display("test %0d %s: ok", id, test_name(id));
      end
      else
      begin
         tests_fail++;
         $display("test %0d %s: FAILED, %0d errors", id, test_name(id), errors - base);
      end
   endtask

   initial
   begin
      int         fd;
      int         n;
      int         fields;
      int         test_id;
      int         cur_test;
      int         base;
      int         perr_i;
      string      line;
      logic [7:0] op;
      iram_addr_t addr;
      iram_word_t wdata;
      iram_word_t exp_word;

      arst_n  = 1'b0;
      address = '0;
      data    = '0;
      wren    = 1'b0;
      rden    = 1'b0;
      repeat (2) @(posedge clk_a);
      #1;
      arst_n = 1'b1;
      repeat (6) @(posedge clk_a);   // any q_valid in this idle stretch is stray
      close_test(6, 0);

      fd = $fopen(stim_file, "r");
      if (fd == 0)
      begin
         $display("error: cannot open %s", stim_file);
         errors++;
      end
      else
      begin
         cur_test = -1;
         base     = errors;
         while (!$feof(fd) && !timed_out)
         begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line.getc(0) != "#")
            begin
               fields = $sscanf(line, "%d %s %h %h %h %d",
                                test_id, op, addr, wdata, exp_word, perr_i);
               if (fields == 6)
               begin
                  if (test_id != cur_test)
                  begin
                     if (cur_test >= 0)
                     begin
                        wait_for_reads();
                        close_test(cur_test, base);
                     end
                     cur_test = test_id;
                     base     = errors;
                  end
                  apply_record(op, addr, wdata, exp_word, perr_i[0]);
               end
            end
         end
         $fclose(fd);
         if (cur_test >= 0)
         begin
            wait_for_reads();
            close_test(cur_test, base);
         end
      end

      repeat (4) @(posedge clk_a);   // no late q_valid
      if (dut0.u_props.fail_cnt != 0)
      begin
         $display("error: %0d assertion failures in the bound checker",
                  dut0.u_props.fail_cnt);
         errors += dut0.u_props.fail_cnt;
      end
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_fail, errors);
      if (errors == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- iram_properties.sv
// IRAM checks bound into the top level
// read latency, bank strobe decode and clean read data
module iram_props (
   input logic                 clk_a,
   input logic                 arst_n,
   input iram_pkg::iram_addr_t address,
   input logic                 wren,
   input logic                 rden,
   input logic                 q_valid,
   input iram_pkg::iram_word_t q,
   input iram_pkg::bank_mask_t bank_wren,
   input iram_pkg::bank_mask_t bank_rden
);
   timeunit 1ns;
   timeprecision 100ps;

   import iram_pkg::*;

   int         fail_cnt = 0;   // failed assertions so far
   bank_mask_t addr_bank;      // one-hot of the addressed bank

   assign addr_bank = bank_mask_t'(1) << address[iram_addr_bits-1 -: bank_sel_bits];

   // each read returns three sampled edges later
   a_rden_to_valid: assert property (@(posedge clk_a) disable iff (!arst_n)
      rden |-> ##3 q_valid)
   else
   begin
      fail_cnt++;
      $error("q_valid missing three clocks after rden");
   end

   // and nothing returns without a read
   a_valid_from_rden: assert property (@(posedge clk_a) disable iff (!arst_n)
      q_valid |-> $past(rden, 3))
   else
   begin
      fail_cnt++;
      $error("q_valid without rden three clocks before");
   end

   // a strobe reaches the addressed bank and no other
   a_wren_onehot: assert property (@(posedge clk_a)
      bank_wren == (wren ? addr_bank : '0))
   else
   begin
      fail_cnt++;
      $error("bank write strobe not on the addressed bank alone");
   end

   a_rden_onehot: assert property (@(posedge clk_a)
      bank_rden == (rden ? addr_bank : '0))
   else
   begin
      fail_cnt++;
      $error("bank read strobe not on the addressed bank alone");
   end

   a_q_known: assert property (@(posedge clk_a) disable iff (!arst_n)
      q_valid |-> !$isunknown(q))
   else
   begin
      fail_cnt++;
      $error("unknown bits on q while q_valid");
   end

endmodule

// attached to every IRAM top level
bind iram_top iram_props u_props (
   .clk_a     (clk_a),
   .arst_n    (arst_n),
   .address   (address),
   .wren      (wren),
   .rden      (rden),
   .q_valid   (q_valid),
   .q         (q),
   .bank_wren (bank_wren),
   .bank_rden (bank_rden)
);

//--- iram_top.sv
// IRAM top level, 16k x 49 microcode store
// bank selector, four RAM banks and the read mux
module iram_top (
   input  logic                 clk_a,
   input  logic                 arst_n,
   input  iram_pkg::iram_addr_t address,
   input  iram_pkg::iram_word_t data,    // parity already in bit 48
   input  logic                 wren,
   input  logic                 rden,
   output iram_pkg::iram_word_t q,
   output logic                 q_valid,       // one cycle per read
   output logic                 parity_error
);
   import iram_pkg::*;

   // selector to banks
   bank_mask_t bank_wren;
   bank_mask_t bank_rden;
   bank_addr_t bank_addr;
   iram_word_t bank_data;

   // banks to mux
   iram_word_t bank_q [iram_banks];

   // selector to mux
   logic       ret_valid;
   bank_sel_t  ret_bank;

   iram_bank_select u_bank_select (
      .clk_a     (clk_a),
      .arst_n    (arst_n),
      .address   (address),
      .data      (data),
      .wren      (wren),
      .rden      (rden),
      .bank_wren (bank_wren),
      .bank_rden (bank_rden),
      .bank_addr (bank_addr),
      .bank_data (bank_data),
      .ret_valid (ret_valid),
      .ret_bank  (ret_bank)
   );

   // one bank per strobe bit
   for (genvar b = 0; b < iram_banks; b++)
   begin : gen_bank
      iram_bank u_bank (
         .clk_a (clk_a),
         .wren  (bank_wren[b]),
         .rden  (bank_rden[b]),
         .addr  (bank_addr),
         .wdata (bank_data),
         .q     (bank_q[b])
      );
   end

   iram_read_mux u_read_mux (
      .clk_a        (clk_a),
      .arst_n       (arst_n),
      .ret_valid    (ret_valid),
      .ret_bank     (ret_bank),
      .q0           (bank_q[0]),
      .q1           (bank_q[1]),
      .q2           (bank_q[2]),
      .q3           (bank_q[3]),
      .q            (q),
      .q_valid      (q_valid),
      .parity_error (parity_error)
   );

endmodule

//--- iram_read_mux.sv
// IRAM read mux
// picks the returning bank's word, registers it and checks odd parity
module iram_read_mux (
   input  logic                 clk_a,
   input  logic                 arst_n,
   input  logic                 ret_valid,   // bank data valid this cycle
   input  iram_pkg::bank_sel_t  ret_bank,
   input  iram_pkg::iram_word_t q0,
   input  iram_pkg::iram_word_t q1,
   input  iram_pkg::iram_word_t q2,
   input  iram_pkg::iram_word_t q3,
   output iram_pkg::iram_word_t q,
   output logic                 q_valid,
   output logic                 parity_error
);
   import iram_pkg::*;

   iram_word_t sel_word;    // word of the returning bank
   logic       sel_odd;     // odd count of ones, the good case

   // bank select
   always_comb
   begin
      case (ret_bank)
         2'd0:    sel_word = q0;
         2'd1:    sel_word = q1;
         2'd2:    sel_word = q2;
         default: sel_word = q3;
      endcase
   end

   // parity over all 49 bits, stored parity included
   assign sel_odd = ^sel_word;

   // output word
   // holds the last returned word between reads
   always_ff @(posedge clk_a)
   begin
      if (ret_valid)
      begin
         q <= sel_word;
      end
   end

   // flags, low out of reset
   always_ff @(posedge clk_a or negedge arst_n)
   begin
      if (!arst_n)
      begin
         q_valid      <= 1'b0;
         parity_error <= 1'b0;
      end
      else
      begin
         q_valid      <= ret_valid;
         parity_error <= ret_valid & ~sel_odd;   // even count means bad word
      end
   end

endmodule

//--- iram_bank_select.sv
// IRAM bank selector
// decodes the host address into per-bank strobes and word address
// and tracks which bank returns data for each read in flight
module iram_bank_select (
   input  logic                 clk_a,
   input  logic                 arst_n,
   input  iram_pkg::iram_addr_t address,
   input  iram_pkg::iram_word_t data,
   input  logic                 wren,
   input  logic                 rden,
   output iram_pkg::bank_mask_t bank_wren,
   output iram_pkg::bank_mask_t bank_rden,
   output iram_pkg::bank_addr_t bank_addr,
   output iram_pkg::iram_word_t bank_data,
   output logic                 ret_valid,   // bank data valid this cycle
   output iram_pkg::bank_sel_t  ret_bank     // which bank it comes from
);
   import iram_pkg::*;

   bank_sel_t  sel;                           // bank index of this access

   // read tracking, one entry per bank stage
   logic       valid_pipe [bank_read_latency];
   bank_sel_t  bank_pipe  [bank_read_latency];

   // upper bits pick the bank, lower bits go to every bank
   assign sel       = address[iram_addr_bits-1 -: bank_sel_bits];
   assign bank_addr = address[bank_addr_bits-1:0];
   assign bank_data = data;                   // shared write bus

   // one-hot strobes
   // only the addressed bank sees wren or rden
   always_comb
   begin
      bank_wren = '0;
      bank_rden = '0;
      if (wren)
      begin
         bank_wren[sel] = 1'b1;
      end
      if (rden)
      begin
         bank_rden[sel] = 1'b1;
      end
   end

   // valid flag delay line, cleared on reset
   always_ff @(posedge clk_a or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < bank_read_latency; i++)
         begin
            valid_pipe[i] <= 1'b0;
         end
      end
      else
      begin
         valid_pipe[0] <= rden;               // read issued this edge
         for (int i = 1; i < bank_read_latency; i++)
         begin
            valid_pipe[i] <= valid_pipe[i-1];
         end
      end
   end

   // bank index delay line
   // only meaningful where the valid flag is set
   always_ff @(posedge clk_a)
   begin
      bank_pipe[0] <= sel;
      for (int i = 1; i < bank_read_latency; i++)
      begin
         bank_pipe[i] <= bank_pipe[i-1];
      end
   end

   // last stage lines up with the bank output register
   assign ret_valid = valid_pipe[bank_read_latency-1];
   assign ret_bank  = bank_pipe[bank_read_latency-1];

endmodule

//--- iram_bank.sv
// IRAM bank holding 4096 words of 49 bits
// behavioural read-first single-port RAM with a two-clock read path
module iram_bank (
   input  logic                 clk_a,
   input  logic                 wren,    // write strobe, one cycle
   input  logic                 rden,    // read strobe, one cycle
   input  iram_pkg::bank_addr_t addr,
   input  iram_pkg::iram_word_t wdata,
   output iram_pkg::iram_word_t q
);
   import iram_pkg::*;

   iram_word_t mem [bank_words];   // storage, contents not cleared
   iram_word_t rd_data;            // first read stage

   // array port
   // the read sees the array before this edge's write lands
   always_ff @(posedge clk_a)
   begin
      if (wren)
      begin
         mem[addr] <= wdata;        // parity bit stored as given
      end
      if (rden)
      begin
         rd_data <= mem[addr];      // old word on a same-edge write
      end
   end

   // output register of the macro
   // free running, the data after a read stays until the next read
   always_ff @(posedge clk_a)
   begin
      q <= rd_data;                 // second read stage
   end

endmodule

//--- iram_pkg.sv
// shared sizes and types for the microcode instruction memory
// 16k words of 48 instruction bits plus odd parity in bit 48
package iram_pkg;

   // word and address geometry
   localparam int iram_word_bits = 49;      // 48 data bits + parity
   localparam int iram_addr_bits = 14;      // 16384 words in total
   localparam int iram_banks     = 4;
   localparam int bank_sel_bits  = 2;       // address bits 13:12
   localparam int bank_addr_bits = 12;      // address bits 11:0
   localparam int bank_words     = 4096;

   // clocks from a bank read strobe to data on the bank output
   localparam int bank_read_latency = 2;

   // rden at the top to q_valid, bank stages plus the mux register
   localparam int iram_read_latency = bank_read_latency + 1;

   // one instruction word, parity in the msb
   typedef logic [iram_word_bits-1:0] iram_word_t;

   // full word address seen by the host
   typedef logic [iram_addr_bits-1:0] iram_addr_t;

   // word address inside one bank
   typedef logic [bank_addr_bits-1:0] bank_addr_t;

   // bank index
   typedef logic [bank_sel_bits-1:0]  bank_sel_t;

   // one strobe bit per bank
   typedef logic [iram_banks-1:0]     bank_mask_t;

endpackage
